// ==== riscv_ex_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types for the EX, MEM and WB stages of the RV32I pipeline
// Data width is fixed at 32 and is not a parameter
// Store type codes follow funct3 of SB, SH and SW
////////////////////////////////////////////////////////////////////////////
package riscv_ex_pkg;

    localparam int XLEN = 32;                // One data word

    typedef logic [XLEN-1:0] word_t;         // Data word
    typedef logic [4:0]      reg_addr_t;     // Register index x0..x31

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,                     // Also used for BEQ compare
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,                     // Register file value
        FWD_WB   = 2'd1,                     // Writeback result
        FWD_MEM  = 2'd2                      // EX/MEM result
    } fwd_sel_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2                       // Link value of JAL/JALR
    } result_src_t;

    typedef enum logic [2:0] {
        ST_BYTE = 3'd0,
        ST_HALF = 3'd1,
        ST_WORD = 3'd2                       // Reset value
    } store_type_t;

    typedef struct packed {
        logic        regwrite;
        logic        memwrite;
        logic        branch;
        logic        jump;
        logic        alusrc;                 // Operand B from immediate
        alu_op_t     aluctrl;
        result_src_t resultsrc;
        store_type_t storetype;
    } ex_ctrl_t;

    typedef struct packed {
        logic        regwrite;
        logic        memwrite;
        result_src_t resultsrc;
        store_type_t storetype;
    } mem_ctrl_t;

    typedef struct packed {
        logic        regwrite;
        result_src_t resultsrc;
    } wb_ctrl_t;

endpackage

// ==== alu.sv ====
////////////////////////////////////////////////////////////////////////////
// Combinational RV32I ALU
// Shift amounts use the low five bits of operand B
// Zero flag reflects the result, so BEQ/BNE rely on ALU_SUB
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module alu (
    input  riscv_ex_pkg::word_t   i_a,
    input  riscv_ex_pkg::word_t   i_b,
    input  riscv_ex_pkg::alu_op_t i_alucontrol,
    output riscv_ex_pkg::word_t   o_result,
    output logic                  o_zero
);

    logic [4:0] shamt;                       // RV32 shift range
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = i_b[4:0];
    assign lt_signed   = $signed(i_a) < $signed(i_b);
    assign lt_unsigned = i_a < i_b;

    always_comb begin
        case (i_alucontrol)
            riscv_ex_pkg::ALU_ADD:  o_result = i_a + i_b;
            riscv_ex_pkg::ALU_SUB:  o_result = i_a - i_b;
            riscv_ex_pkg::ALU_AND:  o_result = i_a & i_b;
            riscv_ex_pkg::ALU_OR:   o_result = i_a | i_b;
            riscv_ex_pkg::ALU_XOR:  o_result = i_a ^ i_b;
            riscv_ex_pkg::ALU_SLL:  o_result = i_a << shamt;
            riscv_ex_pkg::ALU_SRL:  o_result = i_a >> shamt;
            riscv_ex_pkg::ALU_SRA:  o_result = riscv_ex_pkg::word_t'($signed(i_a) >>> shamt);
            riscv_ex_pkg::ALU_SLT:  o_result = {{(riscv_ex_pkg::XLEN-1){1'b0}}, lt_signed};
            riscv_ex_pkg::ALU_SLTU: o_result = {{(riscv_ex_pkg::XLEN-1){1'b0}}, lt_unsigned};
            default:                o_result = '0;   // Unused encodings
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// ==== forwarding_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Forwarding select for the two EX source operands
// MEM wins over WB; x0 is never forwarded
// Load-use hazards are not detected here
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module forwarding_unit (
    input  riscv_ex_pkg::reg_addr_t i_rs1_addr_e,
    input  riscv_ex_pkg::reg_addr_t i_rs2_addr_e,
    input  riscv_ex_pkg::reg_addr_t i_rd_addr_m,
    input  riscv_ex_pkg::reg_addr_t i_rd_addr_w,
    input  logic                    i_regwrite_m,
    input  logic                    i_regwrite_w,
    output riscv_ex_pkg::fwd_sel_t  o_forward_a,
    output riscv_ex_pkg::fwd_sel_t  o_forward_b
);

    // Same test for both operands
    function automatic riscv_ex_pkg::fwd_sel_t pick(input riscv_ex_pkg::reg_addr_t rs);
        riscv_ex_pkg::fwd_sel_t sel;
        sel = riscv_ex_pkg::FWD_NONE;
        if (i_regwrite_m && (i_rd_addr_m != '0) && (i_rd_addr_m == rs))
            sel = riscv_ex_pkg::FWD_MEM;     // Youngest producer
        else if (i_regwrite_w && (i_rd_addr_w != '0) && (i_rd_addr_w == rs))
            sel = riscv_ex_pkg::FWD_WB;
        return sel;
    endfunction

    assign o_forward_a = pick(i_rs1_addr_e);
    assign o_forward_b = pick(i_rs2_addr_e);

    // x0 reads must always see the register file zero
    always_comb begin
        a_no_x0_fwd: assert (((i_rs1_addr_e != '0) || (o_forward_a == riscv_ex_pkg::FWD_NONE))
                          && ((i_rs2_addr_e != '0) || (o_forward_b == riscv_ex_pkg::FWD_NONE)))
            else $error("forwarding path selected for x0");
    end

endmodule

// ==== execute_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Execute stage with operand forwarding and the EX/MEM register
// Branch target and pc_src are combinational in the EX cycle
// PC is ADDR_WIDTH bits; the target wraps at that width
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  riscv_ex_pkg::ex_ctrl_t  i_ctrl_e,
    input  riscv_ex_pkg::word_t     i_rs1_data_e,    // May be stale
    input  riscv_ex_pkg::word_t     i_rs2_data_e,
    input  riscv_ex_pkg::word_t     i_immext_e,      // Sign-extended immediate
    input  logic [ADDR_WIDTH-1:0]   i_pc_e,
    input  logic [ADDR_WIDTH-1:0]   i_pc4_e,
    input  riscv_ex_pkg::reg_addr_t i_rd_addr_e,
    input  riscv_ex_pkg::word_t     i_forward_m,     // MEM stage value
    input  riscv_ex_pkg::word_t     i_forward_w,     // WB stage value
    input  riscv_ex_pkg::fwd_sel_t  i_forward_a,
    input  riscv_ex_pkg::fwd_sel_t  i_forward_b,
    output riscv_ex_pkg::word_t     o_alu_result_m,
    output riscv_ex_pkg::word_t     o_write_data_m,  // Store data
    output riscv_ex_pkg::mem_ctrl_t o_ctrl_m,
    output riscv_ex_pkg::reg_addr_t o_rd_addr_m,
    output logic [ADDR_WIDTH-1:0]   o_pc4_m,
    output logic [ADDR_WIDTH-1:0]   o_pctarget_e,
    output logic                    o_pc_src_e
);

    riscv_ex_pkg::word_t rs1_fwd;
    riscv_ex_pkg::word_t rs2_fwd;
    riscv_ex_pkg::word_t operand_b;
    riscv_ex_pkg::word_t alu_result;
    logic                alu_zero;

    // Three-way operand muxes, order matches fwd_sel_t
    always_comb begin
        case (i_forward_a)
            riscv_ex_pkg::FWD_WB:  rs1_fwd = i_forward_w;
            riscv_ex_pkg::FWD_MEM: rs1_fwd = i_forward_m;
            default:               rs1_fwd = i_rs1_data_e;
        endcase
        case (i_forward_b)
            riscv_ex_pkg::FWD_WB:  rs2_fwd = i_forward_w;
            riscv_ex_pkg::FWD_MEM: rs2_fwd = i_forward_m;
            default:               rs2_fwd = i_rs2_data_e;
        endcase
    end

    assign operand_b = i_ctrl_e.alusrc ? i_immext_e : rs2_fwd;

    alu u_alu (
        .i_a          (rs1_fwd),
        .i_b          (operand_b),
        .i_alucontrol (i_ctrl_e.aluctrl),
        .o_result     (alu_result),
        .o_zero       (alu_zero)
    );

    assign o_pctarget_e = i_pc_e + i_immext_e[ADDR_WIDTH-1:0];   // Truncated target
    assign o_pc_src_e   = i_ctrl_e.jump | (i_ctrl_e.branch & alu_zero);

    // EX/MEM control
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl_m.regwrite  <= 1'b0;
            o_ctrl_m.memwrite  <= 1'b0;
            o_ctrl_m.resultsrc <= riscv_ex_pkg::RES_ALU;
            o_ctrl_m.storetype <= riscv_ex_pkg::ST_WORD;
        end else begin
            o_ctrl_m.regwrite  <= i_ctrl_e.regwrite;
            o_ctrl_m.memwrite  <= i_ctrl_e.memwrite;
            o_ctrl_m.resultsrc <= i_ctrl_e.resultsrc;
            o_ctrl_m.storetype <= i_ctrl_e.storetype;
        end
    end

    // EX/MEM payload
    always_ff @(posedge i_clk) begin
        o_alu_result_m <= alu_result;
        o_write_data_m <= rs2_fwd;           // Forwarded rs2, not the immediate
        o_rd_addr_m    <= i_rd_addr_e;
        o_pc4_m        <= i_pc4_e;
    end

    // Selects come from the forwarding unit
    a_fwd_sel_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_forward_a != 2'd3) && (i_forward_b != 2'd3))
        else $error("illegal forward select");

endmodule

// ==== memory_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory stage with a word-organized data memory and MEM/WB register
// Loads return the full word; sub-word loads are not supported
// Word address wraps modulo DMEM_WORDS; memory has no reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module memory_stage #(
    parameter int ADDR_WIDTH = 10,
    parameter int DMEM_WORDS = 64
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  riscv_ex_pkg::mem_ctrl_t i_ctrl_m,
    input  riscv_ex_pkg::word_t     i_alu_result_m,  // Byte address or result
    input  riscv_ex_pkg::word_t     i_write_data_m,
    input  riscv_ex_pkg::reg_addr_t i_rd_addr_m,
    input  logic [ADDR_WIDTH-1:0]   i_pc4_m,
    output riscv_ex_pkg::word_t     o_fwd_m,
    output riscv_ex_pkg::wb_ctrl_t  o_ctrl_w,
    output riscv_ex_pkg::word_t     o_alu_result_w,
    output riscv_ex_pkg::word_t     o_read_data_w,
    output riscv_ex_pkg::reg_addr_t o_rd_addr_w,
    output logic [ADDR_WIDTH-1:0]   o_pc4_w
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    riscv_ex_pkg::word_t dmem [DMEM_WORDS];
    logic [IDX_W-1:0]    word_idx;
    logic [1:0]          lane;               // Byte lane in the word
    riscv_ex_pkg::word_t read_data;

    assign word_idx  = IDX_W'(i_alu_result_m[riscv_ex_pkg::XLEN-1:2] % DMEM_WORDS);
    assign lane      = i_alu_result_m[1:0];
    assign read_data = dmem[word_idx];       // Asynchronous read

    // A jump in MEM forwards its link value
    assign o_fwd_m = (i_ctrl_m.resultsrc == riscv_ex_pkg::RES_PC4) ?
                     riscv_ex_pkg::word_t'(i_pc4_m) : i_alu_result_m;

    always_ff @(posedge i_clk) begin
        if (i_ctrl_m.memwrite) begin
            case (i_ctrl_m.storetype)
                riscv_ex_pkg::ST_BYTE: dmem[word_idx][{lane, 3'b000} +: 8]   <= i_write_data_m[7:0];
                riscv_ex_pkg::ST_HALF: dmem[word_idx][{lane[1], 4'b0000} +: 16] <= i_write_data_m[15:0];
                default:               dmem[word_idx] <= i_write_data_m;
            endcase
        end
    end

    // MEM/WB control
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl_w.regwrite  <= 1'b0;
            o_ctrl_w.resultsrc <= riscv_ex_pkg::RES_ALU;
        end else begin
            o_ctrl_w.regwrite  <= i_ctrl_m.regwrite;
            o_ctrl_w.resultsrc <= i_ctrl_m.resultsrc;
        end
    end

    // MEM/WB payload
    always_ff @(posedge i_clk) begin
        o_alu_result_w <= i_alu_result_m;
        o_read_data_w  <= read_data;
        o_rd_addr_w    <= i_rd_addr_m;
        o_pc4_w        <= i_pc4_m;
    end

    // Address comes from the EX adder a cycle earlier
    a_store_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ctrl_m.memwrite |->
            !((i_ctrl_m.storetype == riscv_ex_pkg::ST_HALF) && lane[0]) &&
            !((i_ctrl_m.storetype == riscv_ex_pkg::ST_WORD) && (lane != 2'b00)))
        else $error("misaligned store at %h", i_alu_result_m);

endmodule

// ==== writeback_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Writeback result select, purely combinational
// PC+4 is zero-extended from ADDR_WIDTH to the data width
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module writeback_stage #(
    parameter int ADDR_WIDTH = 10
) (
    input  riscv_ex_pkg::wb_ctrl_t  i_ctrl_w,
    input  riscv_ex_pkg::word_t     i_alu_result_w,
    input  riscv_ex_pkg::word_t     i_read_data_w,   // Full load word
    input  riscv_ex_pkg::reg_addr_t i_rd_addr_w,
    input  logic [ADDR_WIDTH-1:0]   i_pc4_w,
    output logic                    o_wb_regwrite,
    output riscv_ex_pkg::reg_addr_t o_wb_rd_addr,
    output riscv_ex_pkg::word_t     o_wb_data
);

    always_comb begin
        case (i_ctrl_w.resultsrc)
            riscv_ex_pkg::RES_MEM: o_wb_data = i_read_data_w;
            riscv_ex_pkg::RES_PC4: o_wb_data = riscv_ex_pkg::word_t'(i_pc4_w);  // Link
            default:               o_wb_data = i_alu_result_w;
        endcase
    end

    assign o_wb_regwrite = i_ctrl_w.regwrite;
    assign o_wb_rd_addr  = i_rd_addr_w;

endmodule

// ==== ex_datapath_top.sv ====
////////////////////////////////////////////////////////////////////////////
// EX/MEM/WB back half of an RV32I pipeline
// Inputs model the ID/EX register; no stalls or flushes
// A load must not be used by the very next instruction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ex_datapath_top #(
    parameter int ADDR_WIDTH = 10,
    parameter int DMEM_WORDS = 64
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  riscv_ex_pkg::ex_ctrl_t  i_ctrl_e,
    input  riscv_ex_pkg::word_t     i_rs1_data_e,
    input  riscv_ex_pkg::word_t     i_rs2_data_e,
    input  riscv_ex_pkg::reg_addr_t i_rs1_addr_e,
    input  riscv_ex_pkg::reg_addr_t i_rs2_addr_e,
    input  riscv_ex_pkg::reg_addr_t i_rd_addr_e,
    input  riscv_ex_pkg::word_t     i_immext_e,
    input  logic [ADDR_WIDTH-1:0]   i_pc_e,
    input  logic [ADDR_WIDTH-1:0]   i_pc4_e,
    output logic [ADDR_WIDTH-1:0]   o_pctarget_e,
    output logic                    o_pc_src_e,
    output logic                    o_wb_regwrite,
    output riscv_ex_pkg::reg_addr_t o_wb_rd_addr,
    output riscv_ex_pkg::word_t     o_wb_data
);

    riscv_ex_pkg::fwd_sel_t  forward_a;
    riscv_ex_pkg::fwd_sel_t  forward_b;
    riscv_ex_pkg::mem_ctrl_t ctrl_m;
    riscv_ex_pkg::word_t     alu_result_m;
    riscv_ex_pkg::word_t     write_data_m;
    riscv_ex_pkg::reg_addr_t rd_addr_m;
    logic [ADDR_WIDTH-1:0]   pc4_m;
    riscv_ex_pkg::word_t     fwd_m;          // MEM forwarding value
    riscv_ex_pkg::wb_ctrl_t  ctrl_w;
    riscv_ex_pkg::word_t     alu_result_w;
    riscv_ex_pkg::word_t     read_data_w;
    riscv_ex_pkg::reg_addr_t rd_addr_w;
    logic [ADDR_WIDTH-1:0]   pc4_w;

    forwarding_unit u_fwd (
        .i_rs1_addr_e (i_rs1_addr_e),
        .i_rs2_addr_e (i_rs2_addr_e),
        .i_rd_addr_m  (rd_addr_m),
        .i_rd_addr_w  (o_wb_rd_addr),
        .i_regwrite_m (ctrl_m.regwrite),
        .i_regwrite_w (o_wb_regwrite),
        .o_forward_a  (forward_a),
        .o_forward_b  (forward_b)
    );

    execute_stage #(.ADDR_WIDTH(ADDR_WIDTH)) u_ex (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ctrl_e       (i_ctrl_e),
        .i_rs1_data_e   (i_rs1_data_e),
        .i_rs2_data_e   (i_rs2_data_e),
        .i_immext_e     (i_immext_e),
        .i_pc_e         (i_pc_e),
        .i_pc4_e        (i_pc4_e),
        .i_rd_addr_e    (i_rd_addr_e),
        .i_forward_m    (fwd_m),
        .i_forward_w    (o_wb_data),         // WB result loops back
        .i_forward_a    (forward_a),
        .i_forward_b    (forward_b),
        .o_alu_result_m (alu_result_m),
        .o_write_data_m (write_data_m),
        .o_ctrl_m       (ctrl_m),
        .o_rd_addr_m    (rd_addr_m),
        .o_pc4_m        (pc4_m),
        .o_pctarget_e   (o_pctarget_e),
        .o_pc_src_e     (o_pc_src_e)
    );

    memory_stage #(.ADDR_WIDTH(ADDR_WIDTH), .DMEM_WORDS(DMEM_WORDS)) u_mem (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ctrl_m       (ctrl_m),
        .i_alu_result_m (alu_result_m),
        .i_write_data_m (write_data_m),
        .i_rd_addr_m    (rd_addr_m),
        .i_pc4_m        (pc4_m),
        .o_fwd_m        (fwd_m),
        .o_ctrl_w       (ctrl_w),
        .o_alu_result_w (alu_result_w),
        .o_read_data_w  (read_data_w),
        .o_rd_addr_w    (rd_addr_w),
        .o_pc4_w        (pc4_w)
    );

    writeback_stage #(.ADDR_WIDTH(ADDR_WIDTH)) u_wb (
        .i_ctrl_w       (ctrl_w),
        .i_alu_result_w (alu_result_w),
        .i_read_data_w  (read_data_w),
        .i_rd_addr_w    (rd_addr_w),
        .i_pc4_w        (pc4_w),
        .o_wb_regwrite  (o_wb_regwrite),
        .o_wb_rd_addr   (o_wb_rd_addr),
        .o_wb_data      (o_wb_data)
    );

endmodule

// ==== tb_ex_datapath.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the EX/MEM/WB datapath that plays fetch, decode and RF
// Register file handed to the DUT lags three instructions behind
// Every load is followed by a bubble; memory words are SW-initialized
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ex_datapath;

    localparam int ADDR_WIDTH = 10;
    localparam int DMEM_WORDS = 64;
    localparam int N_INSTR    = 75;          // Issued slots, bubbles included

    typedef struct packed {
        logic                    regwrite;
        riscv_ex_pkg::reg_addr_t rd;
        riscv_ex_pkg::word_t     data;
    } wb_exp_t;

    logic                    i_clk = 1'b0;
    logic                    i_rst_n = 1'b0;
    riscv_ex_pkg::ex_ctrl_t  i_ctrl_e;
    riscv_ex_pkg::word_t     i_rs1_data_e, i_rs2_data_e, i_immext_e;
    riscv_ex_pkg::reg_addr_t i_rs1_addr_e, i_rs2_addr_e, i_rd_addr_e;
    logic [ADDR_WIDTH-1:0]   i_pc_e, i_pc4_e, o_pctarget_e;
    logic                    o_pc_src_e, o_wb_regwrite;
    riscv_ex_pkg::reg_addr_t o_wb_rd_addr;
    riscv_ex_pkg::word_t     o_wb_data;

    riscv_ex_pkg::word_t   gold_rf [32];     // Up to date after each issue
    riscv_ex_pkg::word_t   rf_stale [32];    // Filled from the writeback port
    riscv_ex_pkg::word_t   gold_mem [DMEM_WORDS];
    wb_exp_t               exp_e = '0, exp_m = '0, exp_w = '0, chk_w = '0;
    string                 name_e = "reset", name_m = "reset", name_w = "reset";
    string                 name_chk = "reset";
    logic                  exp_pc_src = 1'b0;
    logic [ADDR_WIDTH-1:0] exp_target = '0;
    string                 name_pc = "reset";
    int                    seed = 32'h3a85;

    ex_datapath_top #(.ADDR_WIDTH(ADDR_WIDTH), .DMEM_WORDS(DMEM_WORDS)) i_dut (.*);

    always #20 i_clk = ~i_clk;               // 40 ns period

    // Expectation pipe of two stages plus a negedge copy for the checks
    always @(posedge i_clk) begin
        exp_m  <= exp_e;
        exp_w  <= exp_m;
        name_m <= name_e;
        name_w <= name_m;
        if (o_wb_regwrite && (o_wb_rd_addr != '0))
            rf_stale[o_wb_rd_addr] <= o_wb_data;
    end

    always @(negedge i_clk) begin
        chk_w    <= exp_w;
        name_chk <= name_w;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("FAILED %s: expected %h, actual %h", name, expv, actv);
        $display("TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    a_reset_quiet: assert property (@(posedge i_clk) !i_rst_n |-> (!o_wb_regwrite && !o_pc_src_e))
        else report_mismatch("reset", 32'd0,
                             {30'd0, $sampled(o_wb_regwrite), $sampled(o_pc_src_e)});
    a_wb_regwrite: assert property (@(posedge i_clk) o_wb_regwrite == chk_w.regwrite)
        else report_mismatch({name_chk, " regwrite"}, 32'(chk_w.regwrite),
                             32'($sampled(o_wb_regwrite)));
    a_wb_rd: assert property (@(posedge i_clk) chk_w.regwrite |-> (o_wb_rd_addr == chk_w.rd))
        else report_mismatch({name_chk, " rd"}, 32'(chk_w.rd), 32'($sampled(o_wb_rd_addr)));
    a_wb_data: assert property (@(posedge i_clk) chk_w.regwrite |-> (o_wb_data == chk_w.data))
        else report_mismatch({name_chk, " data"}, chk_w.data, $sampled(o_wb_data));
    a_pc_src: assert property (@(posedge i_clk) disable iff (!i_rst_n) o_pc_src_e == exp_pc_src)
        else report_mismatch({name_pc, " pc_src"}, 32'(exp_pc_src), 32'($sampled(o_pc_src_e)));
    a_pc_target: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_pctarget_e == exp_target)
        else report_mismatch({name_pc, " target"}, 32'(exp_target), 32'($sampled(o_pctarget_e)));

    // RV32I operation as the ISA defines it
    function automatic riscv_ex_pkg::word_t ref_alu(input riscv_ex_pkg::alu_op_t op,
                                                    input riscv_ex_pkg::word_t a,
                                                    input riscv_ex_pkg::word_t b);
        case (op)
            riscv_ex_pkg::ALU_ADD:  return a + b;
            riscv_ex_pkg::ALU_SUB:  return a - b;
            riscv_ex_pkg::ALU_AND:  return a & b;
            riscv_ex_pkg::ALU_OR:   return a | b;
            riscv_ex_pkg::ALU_XOR:  return a ^ b;
            riscv_ex_pkg::ALU_SLL:  return a << b[4:0];
            riscv_ex_pkg::ALU_SRL:  return a >> b[4:0];
            riscv_ex_pkg::ALU_SRA:  return riscv_ex_pkg::word_t'($signed(a) >>> b[4:0]);
            riscv_ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:                return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic riscv_ex_pkg::ex_ctrl_t make_ctrl(input logic rw, input logic mw,
        input logic br, input logic jp, input logic src, input riscv_ex_pkg::alu_op_t op,
        input riscv_ex_pkg::result_src_t res, input riscv_ex_pkg::store_type_t st);
        riscv_ex_pkg::ex_ctrl_t c;
        c.regwrite  = rw;
        c.memwrite  = mw;
        c.branch    = br;
        c.jump      = jp;
        c.alusrc    = src;
        c.aluctrl   = op;
        c.resultsrc = res;
        c.storetype = st;
        return c;
    endfunction

    // Present one instruction, update the golden state, wait one cycle
    task automatic issue(input string name, input riscv_ex_pkg::ex_ctrl_t c,
                         input riscv_ex_pkg::reg_addr_t rs1, input riscv_ex_pkg::reg_addr_t rs2,
                         input riscv_ex_pkg::reg_addr_t rd, input riscv_ex_pkg::word_t imm,
                         input logic [ADDR_WIDTH-1:0] pc);
        riscv_ex_pkg::word_t a, b, res, wdata;
        int idx;
        a   = gold_rf[rs1];
        b   = c.alusrc ? imm : gold_rf[rs2];
        res = ref_alu(c.aluctrl, a, b);
        idx = int'(res[31:2]) % DMEM_WORDS;
        if (c.memwrite) begin
            case (c.storetype)
                riscv_ex_pkg::ST_BYTE: gold_mem[idx][res[1:0]*8 +: 8] = gold_rf[rs2][7:0];
                riscv_ex_pkg::ST_HALF: gold_mem[idx][res[1]*16 +: 16] = gold_rf[rs2][15:0];
                default:               gold_mem[idx] = gold_rf[rs2];
            endcase
        end
        wdata = (c.resultsrc == riscv_ex_pkg::RES_MEM) ? gold_mem[idx] :
                (c.resultsrc == riscv_ex_pkg::RES_PC4) ? 32'(pc + ADDR_WIDTH'(4)) : res;
        i_ctrl_e     = c;
        i_rs1_addr_e = rs1;
        i_rs2_addr_e = rs2;
        i_rd_addr_e  = rd;
        i_rs1_data_e = rf_stale[rs1];        // Stale unless forwarded
        i_rs2_data_e = rf_stale[rs2];
        i_immext_e   = imm;
        i_pc_e       = pc;
        i_pc4_e      = pc + ADDR_WIDTH'(4);
        exp_e        = '{regwrite: c.regwrite, rd: rd, data: wdata};
        name_e       = name;
        exp_pc_src   = c.jump | (c.branch & (a == b));
        exp_target   = ADDR_WIDTH'(riscv_ex_pkg::word_t'(pc) + imm);
        name_pc      = name;
        if (c.regwrite && (rd != '0))
            gold_rf[rd] = wdata;
        @(posedge i_clk);
        #1;
    endtask

    task automatic bubble();
        issue("bubble", make_ctrl(0, 0, 0, 0, 0, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd0, 5'd0, 5'd0, '0, '0);
    endtask

    function automatic riscv_ex_pkg::reg_addr_t pick_reg(input int span);
        int r;
        r = $random(seed);
        return riscv_ex_pkg::reg_addr_t'(1 + ((r & 32'h7fff_ffff) % span));
    endfunction

    initial begin
        int op;
        int addr;
        for (int i = 0; i < 32; i++) begin
            gold_rf[i]  = '0;
            rf_stale[i] = '0;
        end
        i_ctrl_e = make_ctrl(0, 0, 0, 0, 0, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
                             riscv_ex_pkg::ST_WORD);
        {i_rs1_data_e, i_rs2_data_e, i_immext_e} = '0;
        {i_rs1_addr_e, i_rs2_addr_e, i_rd_addr_e} = '0;
        {i_pc_e, i_pc4_e} = '0;
        repeat (5) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        // Seed x1..x8 with ADDI
        for (int r = 1; r <= 8; r++)
            issue("addi init", make_ctrl(1, 0, 0, 0, 1, riscv_ex_pkg::ALU_ADD,
                  riscv_ex_pkg::RES_ALU, riscv_ex_pkg::ST_WORD), 5'd0, 5'd0, 5'(r),
                  $random(seed), '0);
        for (op = 0; op < 10; op++) begin
            issue("alu reg", make_ctrl(1, 0, 0, 0, 0, riscv_ex_pkg::alu_op_t'(op),
                  riscv_ex_pkg::RES_ALU, riscv_ex_pkg::ST_WORD), pick_reg(8), pick_reg(8),
                  5'(10 + op), '0, '0);
            issue("alu imm", make_ctrl(1, 0, 0, 0, 1, riscv_ex_pkg::alu_op_t'(op),
                  riscv_ex_pkg::RES_ALU, riscv_ex_pkg::ST_WORD), pick_reg(8), 5'd0,
                  5'(20 + op), $random(seed), '0);
        end
        // Dense chain over x1..x3 hits distances 1, 2 and 3
        for (int i = 0; i < 12; i++)
            issue("fwd chain", make_ctrl(1, 0, 0, 0, 0, riscv_ex_pkg::alu_op_t'(i % 5),
                  riscv_ex_pkg::RES_ALU, riscv_ex_pkg::ST_WORD), pick_reg(3), pick_reg(3),
                  pick_reg(3), '0, '0);
        issue("write x0", make_ctrl(1, 0, 0, 0, 1, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd1, 5'd0, 5'd0, 32'h55, '0);
        issue("read x0", make_ctrl(1, 0, 0, 0, 0, riscv_ex_pkg::ALU_OR, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd0, 5'd0, 5'd9, '0, '0);
        issue("read x0", make_ctrl(1, 0, 0, 0, 0, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd0, 5'd2, 5'd9, '0, '0);
        // SW, SB, SH to one word, then LW with a bubble after it
        for (int i = 0; i < 4; i++) begin
            addr = (($random(seed) & 32'h7fff_ffff) % DMEM_WORDS) * 4;
            issue("sw", make_ctrl(0, 1, 0, 0, 1, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
                  riscv_ex_pkg::ST_WORD), 5'd0, pick_reg(8), 5'd0, 32'(addr), '0);
            issue("sb", make_ctrl(0, 1, 0, 0, 1, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
                  riscv_ex_pkg::ST_BYTE), 5'd0, pick_reg(8), 5'd0, 32'(addr + i), '0);
            issue("sh", make_ctrl(0, 1, 0, 0, 1, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
                  riscv_ex_pkg::ST_HALF), 5'd0, pick_reg(8), 5'd0, 32'(addr + 2 * (i % 2)), '0);
            bubble();
            issue("lw", make_ctrl(1, 0, 0, 0, 1, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_MEM,
                  riscv_ex_pkg::ST_WORD), 5'd0, 5'd0, 5'(26 + i), 32'(addr), '0);
            bubble();
        end
        issue("beq equal", make_ctrl(0, 0, 1, 0, 0, riscv_ex_pkg::ALU_SUB, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd4, 5'd4, 5'd0, 32'h0000_0120, 10'h3f0);
        issue("beq differ", make_ctrl(0, 0, 1, 0, 0, riscv_ex_pkg::ALU_SUB, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd1, 5'd26, 5'd0, 32'hffff_ff80, 10'h040);
        issue("jal", make_ctrl(1, 0, 0, 1, 0, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_PC4,
              riscv_ex_pkg::ST_WORD), 5'd0, 5'd0, 5'd30, $random(seed), 10'h1fc);
        issue("use link", make_ctrl(1, 0, 0, 0, 0, riscv_ex_pkg::ALU_ADD, riscv_ex_pkg::RES_ALU,
              riscv_ex_pkg::ST_WORD), 5'd30, 5'd30, 5'd31, '0, '0);
        repeat (4) bubble();                 // Drain the pipe
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #((N_INSTR + 5 + 20) * 40);
        $display("Timeout: the test sequence did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== flist.f ====
riscv_ex_pkg.sv
alu.sv
forwarding_unit.sv
execute_stage.sv
memory_stage.sv
writeback_stage.sv
ex_datapath_top.sv
tb_ex_datapath.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the EX/MEM/WB datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_ex_datapath -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
